//--- Makefile
TOP := tb_lc3b
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- bench/lc3b_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module lc3b_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    mem_read,
    input logic                    mem_write,
    input logic                    mem_resp,
    input lc3b_pkg::lc3b_word      mem_address,
    input lc3b_pkg::lc3b_word      mem_wdata,
    input lc3b_pkg::lc3b_mem_wmask mem_byte_enable
);

    int fail_count = 0;

    read_write_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    ) else begin
        $error("mem_read and mem_write are high in the same cycle");
        fail_count++;
    end

    // Address held until the memory answers
    read_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_read && !mem_resp) |=> (mem_read && $stable(mem_address))
    ) else begin
        $error("read request dropped or its address moved before mem_resp");
        fail_count++;
    end

    write_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_write && !mem_resp) |=>
            (mem_write && $stable(mem_address) && $stable(mem_wdata))
    ) else begin
        $error("write request dropped or its address or data moved before mem_resp");
        fail_count++;
    end

    request_drops: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((mem_read || mem_write) && mem_resp) |=> !(mem_read || mem_write)
    ) else begin
        $error("memory request still high in the cycle after mem_resp");
        fail_count++;
    end

    write_both_bytes: assert property (
        @(posedge clk) disable iff (!rst_n) mem_write |-> (mem_byte_enable == 2'b11)
    ) else begin
        $error("write without both byte enables");
        fail_count++;
    end

    // Quiet bus during reset and in the cycle after release
    reset_quiet: assert property (
        @(posedge clk) !$past(rst_n) |-> (!mem_read && !mem_write)
    ) else begin
        $error("memory request while in reset or just after it");
        fail_count++;
    end

    first_fetch: assert property (
        @(posedge clk) (rst_n && !$past(rst_n)) |=>
            (mem_read && mem_address == `LC3B_RESET_PC)
    ) else begin
        $error("first fetch after reset does not read the reset PC");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- bench/tb_lc3b.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b;

    // Margin of 8 over 25 instructions of 7 cycles plus two accesses of 4 wait cycles
    localparam int timeout_cycles = 25 * (7 + 2 * 4) * 8;
    localparam int mem_words      = 256;

    localparam lc3b_pkg::lc3b_word data_a = 16'h7a5c;
    localparam lc3b_pkg::lc3b_word data_b = 16'h9c3e;
    localparam lc3b_pkg::lc3b_word data_c = 16'h3c96;

    logic                    clk;
    logic                    rst_n;
    lc3b_pkg::lc3b_word      mem_rdata;
    logic                    mem_resp;
    lc3b_pkg::lc3b_word      mem_address;
    lc3b_pkg::lc3b_word      mem_wdata;
    logic                    mem_read;
    logic                    mem_write;
    lc3b_pkg::lc3b_mem_wmask mem_byte_enable;

    lc3b_pkg::lc3b_word mem [mem_words];
    string              exp_name [$];
    lc3b_pkg::lc3b_word exp_addr [$];
    lc3b_pkg::lc3b_word exp_data [$];
    int                 store_count;
    int                 mismatch_count;
    int                 error_count;

    lc3b_cpu i_dut (.*);

    bind lc3b_cpu lc3b_assertions i_assertions (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Fields are DR or SR with BaseR and offset6, or DR with SR1 and SR2 for ALU operations
    function automatic lc3b_pkg::lc3b_word pack_instr(
        lc3b_pkg::lc3b_opcode op, logic [2:0] a, logic [2:0] b, logic [5:0] low
    );
        return {op, a, b, low};
    endfunction

    function automatic lc3b_pkg::lc3b_word branch_instr(logic [2:0] nzp, logic [8:0] offset9);
        return {lc3b_pkg::op_br, nzp, offset9};
    endfunction

    task automatic add_expected(string name, lc3b_pkg::lc3b_word addr,
                                lc3b_pkg::lc3b_word data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_program;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 16'hf000 | 16'(i);
        end
        mem[0]  = pack_instr(lc3b_pkg::op_ldr, 3'd7, 3'd0, 6'd31);
        mem[1]  = pack_instr(lc3b_pkg::op_ldr, 3'd1, 3'd7, 6'd0);
        mem[2]  = pack_instr(lc3b_pkg::op_ldr, 3'd2, 3'd7, 6'd1);
        mem[3]  = pack_instr(lc3b_pkg::op_ldr, 3'd6, 3'd7, 6'd2);
        mem[4]  = pack_instr(lc3b_pkg::op_add, 3'd3, 3'd1, 6'd2);
        mem[5]  = pack_instr(lc3b_pkg::op_str, 3'd3, 3'd7, 6'd16);
        mem[6]  = pack_instr(lc3b_pkg::op_and, 3'd4, 3'd1, 6'd2);
        mem[7]  = pack_instr(lc3b_pkg::op_str, 3'd4, 3'd7, 6'd17);
        mem[8]  = pack_instr(lc3b_pkg::op_not, 3'd5, 3'd1, 6'h3f);
        mem[9]  = pack_instr(lc3b_pkg::op_str, 3'd5, 3'd7, 6'd18);
        // With n set BRn skips the marker and BRzp falls through
        mem[10] = branch_instr(3'b100, 9'd1);
        mem[11] = pack_instr(lc3b_pkg::op_str, 3'd5, 3'd7, 6'd19);
        mem[12] = branch_instr(3'b011, 9'd1);
        mem[13] = pack_instr(lc3b_pkg::op_str, 3'd1, 3'd7, 6'd20);
        mem[14] = pack_instr(lc3b_pkg::op_and, 3'd3, 3'd1, 6'd0);
        mem[15] = branch_instr(3'b010, 9'd1);
        mem[16] = pack_instr(lc3b_pkg::op_str, 3'd5, 3'd7, 6'd21);
        mem[17] = branch_instr(3'b101, 9'd1);
        mem[18] = pack_instr(lc3b_pkg::op_str, 3'd2, 3'd7, 6'd22);
        // Negative offsets from 0x0180
        mem[19] = pack_instr(lc3b_pkg::op_ldr, 3'd1, 3'd6, 6'h20);
        mem[20] = branch_instr(3'b001, 9'd1);
        mem[21] = pack_instr(lc3b_pkg::op_str, 3'd5, 3'd7, 6'd23);
        mem[22] = branch_instr(3'b110, 9'd1);
        mem[23] = pack_instr(lc3b_pkg::op_str, 3'd1, 3'd6, 6'h3c);
        mem[24] = branch_instr(3'b111, 9'h1ff);
        mem[31] = 16'h0100;
        mem[8'h80] = data_a;
        mem[8'h81] = data_b;
        mem[8'h82] = 16'h0180;
        mem[8'ha0] = data_c;
        add_expected("add", 16'h0120, data_a + data_b);
        add_expected("and", 16'h0122, data_a & data_b);
        add_expected("not", 16'h0124, ~data_a);
        add_expected("br_zp_not_taken", 16'h0128, data_a);
        add_expected("br_np_not_taken", 16'h012c, data_b);
        add_expected("ldr_str_copy", 16'h0178, data_c);
    endtask

    task automatic check_store;
        assert (!(mem_address inside {16'h0126, 16'h012a, 16'h012e})) else begin
            $display("Store to %h, the marker of a taken branch that should be skipped",
                     mem_address);
            error_count++;
        end
        if (store_count >= exp_addr.size()) begin
            $display("Unexpected extra store of %h to address %h", mem_wdata, mem_address);
            error_count++;
        end else begin
            assert (mem_address == exp_addr[store_count]) else begin
                $display("MISMATCH %s address: expected %h, actual %h",
                         exp_name[store_count], exp_addr[store_count], mem_address);
                mismatch_count++;
            end
            assert (mem_wdata == exp_data[store_count]) else begin
                $display("MISMATCH %s data: expected %h, actual %h",
                         exp_name[store_count], exp_data[store_count], mem_wdata);
                mismatch_count++;
            end
        end
        store_count++;
    endtask

    task automatic finish_run;
        int assertion_failures;
        assertion_failures = i_dut.i_assertions.fail_count;
        $display("Mismatches: %0d, other errors: %0d, bus assertion failures: %0d",
                 mismatch_count, error_count, assertion_failures);
        if (mismatch_count == 0 && error_count == 0 && assertion_failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Memory answers each access after 1 to 4 wait cycles
    initial begin : memory_model
        int unsigned wait_cycles;
        void'($urandom(32'hea38));
        mem_resp  = 1'b0;
        mem_rdata = '0;
        @(posedge clk);
        #1;
        forever begin
            if (rst_n && (mem_read || mem_write)) begin
                wait_cycles = $urandom_range(4, 1);
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                if (mem_write) begin
                    check_store();
                    mem[mem_address[8:1]] = mem_wdata;
                end else begin
                    mem_rdata = mem[mem_address[8:1]];
                end
                mem_resp = 1'b1;
            end
            @(posedge clk);
            #1;
            mem_resp = 1'b0;
        end
    end

    initial begin : main_sequence
        rst_n          = 1'b0;
        store_count    = 0;
        mismatch_count = 0;
        error_count    = 0;
        load_program();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (store_count >= exp_addr.size());
        // Let the final self-loop spin so stray stores show up
        repeat (100) @(posedge clk);
        finish_run();
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, only %0d of %0d expected stores arrived",
                 timeout_cycles, store_count, exp_addr.size());
        error_count++;
        finish_run();
    end

endmodule

`default_nettype wire

//--- common/lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// PC value loaded by reset, first instruction fetch address
`define LC3B_RESET_PC 16'h0000

// Architectural register count
`define LC3B_NUM_REGS 8

// Data and address width
`define LC3B_WORD_WIDTH 16

`endif

//--- common/lc3b_pkg.sv
`default_nettype none

`include "lc3b_params.svh"

package lc3b_pkg;

    // Data and address word
    typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;

    // Register file index, sized from the register count
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    // Byte enables for the memory bus, bit 1 is the high byte
    typedef logic [1:0] lc3b_mem_wmask;

    // Opcodes of the supported subset at their LC-3b encodings
    // Other encodings decode as a no-op
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // ALU functions
    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass   // first operand straight through
    } lc3b_aluop;

endpackage

`default_nettype wire

//--- control/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lc3b_pkg::lc3b_opcode    opcode,
    input  logic                    branch_enable,
    input  logic                    mem_resp,
    output logic                    load_pc,
    output logic                    load_ir,
    output logic                    load_regfile,
    output logic                    load_mar,
    output logic                    load_mdr,
    output logic                    load_cc,
    output logic                    pcmux_sel,
    output logic                    storemux_sel,
    output logic                    alumux_sel,
    output logic                    regfilemux_sel,
    output logic                    marmux_sel,
    output logic                    mdrmux_sel,
    output lc3b_pkg::lc3b_aluop     aluop,
    output logic                    mem_read,
    output logic                    mem_write,
    output lc3b_pkg::lc3b_mem_wmask mem_byte_enable
);

    typedef enum logic [3:0] {
        fetch1,
        fetch2,
        fetch3,
        decode,
        s_add,
        s_and,
        s_not,
        br,
        br_taken,
        calc_addr,
        ldr1,
        ldr2,
        str1,
        str2
    } state_t;

    state_t state;
    state_t next_state;

    // Datapath controls, defaults first and overridden per state
    always_comb begin : state_actions
        load_pc         = 1'b0;
        load_ir         = 1'b0;
        load_regfile    = 1'b0;
        load_mar        = 1'b0;
        load_mdr        = 1'b0;
        load_cc         = 1'b0;
        pcmux_sel       = 1'b0;
        storemux_sel    = 1'b0;
        alumux_sel      = 1'b0;
        regfilemux_sel  = 1'b0;
        marmux_sel      = 1'b0;
        mdrmux_sel      = 1'b0;
        aluop           = lc3b_pkg::alu_add;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = 2'b11;

        case (state)
            fetch1: begin
                // MAR <= PC and PC <= PC + 2
                marmux_sel = 1'b1;
                load_mar   = 1'b1;
                load_pc    = 1'b1;
            end
            fetch2, ldr1: begin
                // Hold the read until the memory answers
                mem_read   = 1'b1;
                mdrmux_sel = 1'b1;
                load_mdr   = mem_resp;
            end
            fetch3: begin
                load_ir = 1'b1;
            end
            s_add, s_and, s_not: begin
                if (state == s_add) begin
                    aluop = lc3b_pkg::alu_add;
                end else if (state == s_and) begin
                    aluop = lc3b_pkg::alu_and;
                end else begin
                    aluop = lc3b_pkg::alu_not;
                end
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            br_taken: begin
                pcmux_sel = 1'b1;
                load_pc   = 1'b1;
            end
            calc_addr: begin
                // Base register plus scaled offset6
                alumux_sel = 1'b1;
                load_mar   = 1'b1;
            end
            ldr2: begin
                regfilemux_sel = 1'b1;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            str1: begin
                // Source register into MDR through the ALU
                storemux_sel = 1'b1;
                aluop        = lc3b_pkg::alu_pass;
                load_mdr     = 1'b1;
            end
            str2: begin
                mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin : next_state_logic
        next_state = state;
        case (state)
            fetch1:    next_state = fetch2;
            fetch2:    next_state = mem_resp ? fetch3 : fetch2;
            fetch3:    next_state = decode;
            decode: begin
                case (opcode)
                    lc3b_pkg::op_add: next_state = s_add;
                    lc3b_pkg::op_and: next_state = s_and;
                    lc3b_pkg::op_not: next_state = s_not;
                    lc3b_pkg::op_br:  next_state = br;
                    lc3b_pkg::op_ldr: next_state = calc_addr;
                    lc3b_pkg::op_str: next_state = calc_addr;
                    default:          next_state = fetch1;
                endcase
            end
            br:        next_state = branch_enable ? br_taken : fetch1;
            calc_addr: next_state = (opcode == lc3b_pkg::op_ldr) ? ldr1 : str1;
            ldr1:      next_state = mem_resp ? ldr2 : ldr1;
            str1:      next_state = str2;
            str2:      next_state = mem_resp ? fetch1 : str2;
            // Single-cycle execute states all end the instruction
            default:   next_state = fetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fetch1;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_pc,
    input  logic                 load_ir,
    input  logic                 load_regfile,
    input  logic                 load_mar,
    input  logic                 load_mdr,
    input  logic                 load_cc,
    input  logic                 pcmux_sel,
    input  logic                 storemux_sel,
    input  logic                 alumux_sel,
    input  logic                 regfilemux_sel,
    input  logic                 marmux_sel,
    input  logic                 mdrmux_sel,
    input  lc3b_pkg::lc3b_aluop  aluop,
    input  lc3b_pkg::lc3b_word   mem_rdata,
    output lc3b_pkg::lc3b_opcode opcode,
    output logic                 branch_enable,
    output lc3b_pkg::lc3b_word   mem_address,
    output lc3b_pkg::lc3b_word   mem_wdata
);

    lc3b_pkg::lc3b_word pc;
    lc3b_pkg::lc3b_word ir;
    lc3b_pkg::lc3b_word mar;
    lc3b_pkg::lc3b_word mdr;
    logic [2:0]         cc;
    logic [2:0]         cc_next;

    lc3b_pkg::lc3b_word pc_plus2;
    lc3b_pkg::lc3b_word adj9;
    lc3b_pkg::lc3b_word adj6;
    lc3b_pkg::lc3b_word pcmux_out;
    lc3b_pkg::lc3b_word marmux_out;
    lc3b_pkg::lc3b_word mdrmux_out;
    lc3b_pkg::lc3b_word regfile_in;
    lc3b_pkg::lc3b_word reg_a;
    lc3b_pkg::lc3b_word reg_b;
    lc3b_pkg::lc3b_word alu_b;
    lc3b_pkg::lc3b_word alu_out;
    lc3b_pkg::lc3b_reg  src_a;

    assign opcode      = lc3b_pkg::lc3b_opcode'(ir[15:12]);
    assign mem_address = mar;
    assign mem_wdata   = mdr;

    // Word-scaled offsets
    assign adj9 = {{6{ir[8]}}, ir[8:0], 1'b0};
    assign adj6 = {{9{ir[5]}}, ir[5:0], 1'b0};

    // PC already holds PC + 2 when a branch is taken
    assign pc_plus2  = pc + 16'd2;
    assign pcmux_out = pcmux_sel ? (pc + adj9) : pc_plus2;

    // STR reads its source from IR[11:9] in the same port as SR1
    assign src_a = storemux_sel ? ir[11:9] : ir[8:6];
    assign alu_b = alumux_sel ? adj6 : reg_b;

    always_comb begin
        case (aluop)
            lc3b_pkg::alu_add: alu_out = reg_a + alu_b;
            lc3b_pkg::alu_and: alu_out = reg_a & alu_b;
            lc3b_pkg::alu_not: alu_out = ~reg_a;
            default:           alu_out = reg_a;
        endcase
    end

    assign marmux_out = marmux_sel ? pc : alu_out;
    assign mdrmux_out = mdrmux_sel ? mem_rdata : alu_out;
    assign regfile_in = regfilemux_sel ? mdr : alu_out;

    // nzp of the value being written back
    always_comb begin
        if (regfile_in[15]) begin
            cc_next = 3'b100;
        end else if (regfile_in == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    assign branch_enable = |(ir[11:9] & cc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `LC3B_RESET_PC;
            ir <= '0;
            cc <= 3'b010;
        end else begin
            if (load_pc) begin
                pc <= pcmux_out;
            end
            if (load_ir) begin
                ir <= mdr;
            end
            if (load_cc) begin
                cc <= cc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_mar) begin
            mar <= marmux_out;
        end
        if (load_mdr) begin
            mdr <= mdrmux_out;
        end
    end

    regfile i_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_regfile (load_regfile),
        .src_a        (src_a),
        .src_b        (ir[2:0]),
        .dest         (ir[11:9]),
        .in           (regfile_in),
        .reg_a        (reg_a),
        .reg_b        (reg_b)
    );

endmodule

`default_nettype wire

//--- hdl/lc3b_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lc3b_pkg::lc3b_word      mem_rdata,
    input  logic                    mem_resp,
    output lc3b_pkg::lc3b_word      mem_address,
    output lc3b_pkg::lc3b_word      mem_wdata,
    output logic                    mem_read,
    output logic                    mem_write,
    output lc3b_pkg::lc3b_mem_wmask mem_byte_enable
);

    // Control to datapath
    logic load_pc;
    logic load_ir;
    logic load_regfile;
    logic load_mar;
    logic load_mdr;
    logic load_cc;
    logic pcmux_sel;
    logic storemux_sel;
    logic alumux_sel;
    logic regfilemux_sel;
    logic marmux_sel;
    logic mdrmux_sel;
    lc3b_pkg::lc3b_aluop aluop;

    // Datapath to control
    lc3b_pkg::lc3b_opcode opcode;
    logic                 branch_enable;

    // Port names match the nets above one to one
    control i_control (.*);

    datapath i_datapath (.*);

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_regfile,
    input  lc3b_pkg::lc3b_reg  src_a,
    input  lc3b_pkg::lc3b_reg  src_b,
    input  lc3b_pkg::lc3b_reg  dest,
    input  lc3b_pkg::lc3b_word in,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);

    lc3b_pkg::lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load_regfile) begin
            regs[dest] <= in;
        end
    end

    // Combinational reads, a write shows up after the edge
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/lc3b_pkg.sv
hdl/regfile.sv
datapath/datapath.sv
control/control.sv
hdl/lc3b_cpu.sv
bench/lc3b_assertions.sv
bench/tb_lc3b.sv
